// File: design/frontend_macros.svh
// sizes are fixed here; table index slicing assumes 16 entries and word-aligned fetch addresses
`ifndef FRONTEND_MACROS_SVH
`define FRONTEND_MACROS_SVH

// ------------------------------
// widths
// ------------------------------
// virtual fetch address
`define FE_VLEN 32
// one uncompressed instruction word
`define FE_ILEN 32

// ------------------------------
// branch history table
// ------------------------------
// depth, must stay a power of two
`define FE_BHT_ENTRIES 16
// log2 of depth, index taken from pc bit 2 upward
`define FE_BHT_IDX_W 4
// saturating counter width
`define FE_BHT_CNT_W 2

// major opcodes that the scanner recognizes
`define FE_OPC_BRANCH 7'b1100011
`define FE_OPC_JAL 7'b1101111

`endif

// File: design/frontend_pkg.sv
// shared frontend types; only rv32 uncompressed encodings, no compressed or jalr target types
`default_nettype none

package frontend_pkg;

  `include "frontend_macros.svh"

  // fetch / instruction address
  typedef logic [`FE_VLEN-1:0] vaddr_t;

  // two-bit saturating counter
  // 0..1 predict not taken, 2..3 predict taken
  typedef logic [`FE_BHT_CNT_W-1:0] bht_cnt_t;

  // kind of control flow found in a fetched word
  typedef enum logic [1:0] {
    cf_none   = 2'd0,
    cf_branch = 2'd1,
    cf_jump   = 2'd2
  } cf_kind_e;

  // ------------------------------
  // instruction word, two views
  // ------------------------------
  typedef union packed {
    // conditional branch layout
    struct packed {
      logic       imm12;
      logic [5:0] imm10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm4_1;
      logic       imm11;
      logic [6:0] opcode;
    } btype;
    // jal layout
    struct packed {
      logic       imm20;
      logic [9:0] imm10_1;
      logic       imm11;
      logic [7:0] imm19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } jtype;
  } instr_u;

endpackage

`default_nettype wire

// File: design/instr_scan.sv
// purely combinational; recognizes only rv32 branch and jal, jalr and compressed words count as none
`default_nettype none

`include "frontend_macros.svh"

module instr_scan
  import frontend_pkg::*;
(
  // fetched word
  input  instr_u   instr_i,
  // classification result
  output cf_kind_e cf_kind_o,
  // sign-extended pc-relative offset, zero when not a control-flow word
  output vaddr_t   offset_o
);

  // opcode sits in the same bits in both views
  logic [6:0] opcode;
  // assembled immediates of both formats
  vaddr_t     b_imm;
  vaddr_t     j_imm;

  assign opcode = instr_i.btype.opcode;

  // ------------------------------
  // immediate assembly
  // ------------------------------
  // b-type: imm[12|10:5] in the top, imm[4:1|11] next to the opcode
  assign b_imm = {{(`FE_VLEN-13){instr_i.btype.imm12}},
                  instr_i.btype.imm12,
                  instr_i.btype.imm11,
                  instr_i.btype.imm10_5,
                  instr_i.btype.imm4_1,
                  1'b0};

  // j-type: imm[20|10:1|11|19:12]
  assign j_imm = {{(`FE_VLEN-21){instr_i.jtype.imm20}},
                  instr_i.jtype.imm20,
                  instr_i.jtype.imm19_12,
                  instr_i.jtype.imm11,
                  instr_i.jtype.imm10_1,
                  1'b0};

  // ------------------------------
  // classification
  // ------------------------------
  always_comb begin
    cf_kind_o = cf_none;
    offset_o  = '0;
    case (opcode)
      `FE_OPC_BRANCH: begin
        cf_kind_o = cf_branch;
        offset_o  = b_imm;
      end
      `FE_OPC_JAL: begin
        cf_kind_o = cf_jump;
        offset_o  = j_imm;
      end
      // jalr, alu, loads, everything else
      default: ;
    endcase
  end

endmodule

`default_nettype wire

// File: design/branch_history.sv
// direct-mapped, untagged history table; aliasing pcs share an entry, write visible one edge later
`default_nettype none

`include "frontend_macros.svh"

module branch_history
  import frontend_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  // read side, current fetch address
  input  vaddr_t lookup_pc_i,
  // training from resolved branches
  input  logic   update_valid_i,
  input  vaddr_t update_pc_i,
  input  logic   update_taken_i,
  // entry has been trained at least once
  output logic   pred_valid_o,
  // counter msb
  output logic   pred_taken_o
);

  // per-entry state
  logic     [`FE_BHT_ENTRIES-1:0] valid_q;
  bht_cnt_t                       cnt_q [`FE_BHT_ENTRIES];

  // word-aligned index, bit 2 upward
  logic [`FE_BHT_IDX_W-1:0] lookup_idx;
  logic [`FE_BHT_IDX_W-1:0] update_idx;
  // next counter value for the entry being trained
  bht_cnt_t                 cnt_new;

  assign lookup_idx = lookup_pc_i[`FE_BHT_IDX_W+1:2];
  assign update_idx = update_pc_i[`FE_BHT_IDX_W+1:2];

  // ------------------------------
  // read
  // ------------------------------
  assign pred_valid_o = valid_q[lookup_idx];
  assign pred_taken_o = cnt_q[lookup_idx][`FE_BHT_CNT_W-1];

  // ------------------------------
  // counter update
  // ------------------------------
  always_comb begin
    cnt_new = cnt_q[update_idx];
    if (!valid_q[update_idx]) begin
      // first training lands on the weak state of the outcome
      cnt_new = update_taken_i ? bht_cnt_t'(2) : bht_cnt_t'(1);
    end else if (update_taken_i) begin
      // saturate at strongly taken
      if (cnt_q[update_idx] != '1) begin
        cnt_new = cnt_q[update_idx] + bht_cnt_t'(1);
      end
    end else begin
      // saturate at strongly not taken
      if (cnt_q[update_idx] != '0) begin
        cnt_new = cnt_q[update_idx] - bht_cnt_t'(1);
      end
    end
  end

  // valid bits are control state
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      valid_q <= '0;
    end else if (update_valid_i) begin
      valid_q[update_idx] <= 1'b1;
    end
  end

  // counters are only read once their valid bit is set
  always_ff @(posedge clk_i) begin
    if (update_valid_i) begin
      cnt_q[update_idx] <= cnt_new;
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_pc_gen.sv
// one-deep entry register, no queue; redirect beats everything and drops the pending entry
`default_nettype none

`include "frontend_macros.svh"

module fetch_pc_gen
  import frontend_pkg::*;
(
  input  logic     clk_i,
  input  logic     rst_ni,
  // first fetch address after reset
  input  vaddr_t   boot_addr_i,
  // fetch source side
  input  logic     fetch_valid_i,
  input  instr_u   fetch_instr_i,
  // scanner results
  input  cf_kind_e cf_kind_i,
  input  vaddr_t   offset_i,
  // history table results
  input  logic     pred_valid_i,
  input  logic     pred_taken_i,
  // mispredict from the back end
  input  logic     redirect_valid_i,
  input  vaddr_t   redirect_pc_i,
  // decode side
  input  logic     entry_ready_i,
  output vaddr_t   fetch_addr_o,
  output logic     fetch_ready_o,
  output logic     entry_valid_o,
  output vaddr_t   entry_pc_o,
  output instr_u   entry_instr_o,
  output logic     entry_pred_taken_o,
  output vaddr_t   entry_pred_target_o
);

  // set during reset so the first fetch uses boot_addr_i
  logic   rst_load_q;
  vaddr_t pc_q;
  vaddr_t fetch_addr;
  vaddr_t pc_next;
  vaddr_t pred_target;
  logic   pred_taken;
  logic   accept;

  // ------------------------------
  // fetch address and handshake
  // ------------------------------
  assign fetch_addr   = rst_load_q ? boot_addr_i : pc_q;
  assign fetch_addr_o = fetch_addr;

  // room when empty or draining this cycle, never while redirecting
  assign fetch_ready_o = (!entry_valid_o || entry_ready_i) && !redirect_valid_i;
  assign accept        = fetch_valid_i && fetch_ready_o;

  // ------------------------------
  // prediction
  // ------------------------------
  assign pred_target = fetch_addr + offset_i;

  always_comb begin
    case (cf_kind_i)
      // jal always taken
      cf_jump:   pred_taken = 1'b1;
      // trained entry wins, else backward taken
      cf_branch: pred_taken = pred_valid_i ? pred_taken_i : offset_i[`FE_VLEN-1];
      default:   pred_taken = 1'b0;
    endcase
  end

  // redirect, then taken target, then sequential
  always_comb begin
    pc_next = fetch_addr;
    if (redirect_valid_i) begin
      pc_next = redirect_pc_i;
    end else if (accept) begin
      pc_next = pred_taken ? pred_target : fetch_addr + vaddr_t'(`FE_ILEN / 8);
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rst_load_q    <= 1'b1;
      pc_q          <= '0;
      entry_valid_o <= 1'b0;
    end else begin
      rst_load_q <= 1'b0;
      pc_q       <= pc_next;
      if (redirect_valid_i) begin
        entry_valid_o <= 1'b0;
      end else if (accept) begin
        entry_valid_o <= 1'b1;
      end else if (entry_ready_i) begin
        entry_valid_o <= 1'b0;
      end
    end
  end

  // entry payload, held while decode stalls
  always_ff @(posedge clk_i) begin
    if (accept) begin
      entry_pc_o          <= fetch_addr;
      entry_instr_o       <= fetch_instr_i;
      entry_pred_taken_o  <= pred_taken;
      entry_pred_target_o <= pred_target;
    end
  end

endmodule

`default_nettype wire

// File: design/fetch_frontend.sv
// single-issue rv32 fetch top; fetch_instr_i must be the word at fetch_addr_o, no compressed code
`default_nettype none

module fetch_frontend
  import frontend_pkg::*;
(
  input  logic   clk_i,
  input  logic   rst_ni,
  input  vaddr_t boot_addr_i,
  // fetch source
  input  logic   fetch_valid_i,
  input  instr_u fetch_instr_i,
  output logic   fetch_ready_o,
  output vaddr_t fetch_addr_o,
  // back-end redirect
  input  logic   redirect_valid_i,
  input  vaddr_t redirect_pc_i,
  // resolved branch training
  input  logic   resolve_valid_i,
  input  vaddr_t resolve_pc_i,
  input  logic   resolve_taken_i,
  // decode
  output logic   entry_valid_o,
  output vaddr_t entry_pc_o,
  output instr_u entry_instr_o,
  output logic   entry_pred_taken_o,
  output vaddr_t entry_pred_target_o,
  input  logic   entry_ready_i
);

  cf_kind_e cf_kind;
  vaddr_t   offset;
  logic     pred_valid;
  logic     pred_taken;

  // ------------------------------
  // scan and history side by side
  // ------------------------------
  instr_scan u_instr_scan (
    .instr_i   (fetch_instr_i),
    .cf_kind_o (cf_kind),
    .offset_o  (offset)
  );

  // looked up with the address currently being fetched
  branch_history u_branch_history (
    .clk_i          (clk_i),
    .rst_ni         (rst_ni),
    .lookup_pc_i    (fetch_addr_o),
    .update_valid_i (resolve_valid_i),
    .update_pc_i    (resolve_pc_i),
    .update_taken_i (resolve_taken_i),
    .pred_valid_o   (pred_valid),
    .pred_taken_o   (pred_taken)
  );

  // pc register, prediction merge and entry register
  fetch_pc_gen u_fetch_pc_gen (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_instr_i       (fetch_instr_i),
    .cf_kind_i           (cf_kind),
    .offset_i            (offset),
    .pred_valid_i        (pred_valid),
    .pred_taken_i        (pred_taken),
    .redirect_valid_i    (redirect_valid_i),
    .redirect_pc_i       (redirect_pc_i),
    .entry_ready_i       (entry_ready_i),
    .fetch_addr_o        (fetch_addr_o),
    .fetch_ready_o       (fetch_ready_o),
    .entry_valid_o       (entry_valid_o),
    .entry_pc_o          (entry_pc_o),
    .entry_instr_o       (entry_instr_o),
    .entry_pred_taken_o  (entry_pred_taken_o),
    .entry_pred_target_o (entry_pred_target_o)
  );

endmodule

`default_nettype wire

// File: testbench/tb_vectors.svh
// stimulus rows for the fetch frontend testbench; resolve fields act at the edge that accepts the row's word
`ifndef TB_VECTORS_SVH
`define TB_VECTORS_SVH

// ------------------------------
// instruction words used by the rows
// ------------------------------
// addi x1, x0, 1
localparam logic [31:0] I_ALU      = 32'h0010_0093;
// jalr x0, 0(x1), never predicted
localparam logic [31:0] I_JALR     = 32'h0000_8067;
// beq x0, x0, +16
localparam logic [31:0] I_BEQ_FWD  = 32'h0000_0863;
// bne x1, x0, -8
localparam logic [31:0] I_BNE_BACK = 32'hfe00_9ce3;
// jal x0, +32
localparam logic [31:0] I_JAL_POS  = 32'h0200_006f;
// jal x0, -16
localparam logic [31:0] I_JAL_NEG  = 32'hff1f_f06f;
localparam logic [31:0] NO_ADDR    = 32'h0000_0000;

localparam int NUM_ROWS      = 16;
// largest stall count in the table below
localparam int ROW_STALL_MAX = 3;

typedef struct packed {
  logic [31:0] instr;
  logic [3:0]  stall;
  logic        redir_valid;
  logic [31:0] redir_pc;
  logic        res_valid;
  logic [31:0] res_pc;
  logic        res_taken;
} vec_row_t;

// columns: instr, stall, redirect valid, redirect pc, resolve valid, resolve pc, resolve taken
function automatic vec_row_t vector_row(input int idx);
  case (idx)
    0:  return {I_ALU,      4'd1, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    1:  return {I_JALR,     4'd0, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    2:  return {I_BEQ_FWD,  4'd2, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    3:  return {I_BNE_BACK, 4'd0, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    4:  return {I_JAL_POS,  4'd1, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    5:  return {I_JAL_NEG,  4'd0, 1'b1, 32'h0000_2000, 1'b0, NO_ADDR,       1'b0};
    6:  return {I_ALU,      4'd3, 1'b0, NO_ADDR,       1'b1, 32'h0000_2004, 1'b1};
    7:  return {I_BNE_BACK, 4'd0, 1'b1, 32'h0000_2004, 1'b1, 32'h0000_2004, 1'b0};
    8:  return {I_BNE_BACK, 4'd1, 1'b0, NO_ADDR,       1'b1, 32'h0000_2004, 1'b0};
    9:  return {I_BEQ_FWD,  4'd0, 1'b1, 32'h0000_2008, 1'b1, 32'h0000_2008, 1'b1};
    10: return {I_BEQ_FWD,  4'd2, 1'b0, NO_ADDR,       1'b1, 32'h0000_2008, 1'b1};
    11: return {I_ALU,      4'd0, 1'b1, 32'h0000_2008, 1'b1, 32'h0000_2008, 1'b1};
    12: return {I_BEQ_FWD,  4'd1, 1'b0, NO_ADDR,       1'b1, 32'h0000_2008, 1'b0};
    13: return {I_ALU,      4'd3, 1'b1, 32'h0000_2004, 1'b1, 32'h0000_2004, 1'b0};
    14: return {I_BNE_BACK, 4'd0, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    15: return {I_JALR,     4'd2, 1'b0, NO_ADDR,       1'b0, NO_ADDR,       1'b0};
    default: return '0;
  endcase
endfunction

`endif

// File: testbench/tb_fetch_frontend.sv
// one row in flight at a time, decode stalls between rows; resolves only at accept edges
`default_nettype none

`include "frontend_macros.svh"

module tb_fetch_frontend
  import frontend_pkg::*;
();

  timeunit 1ns;
  timeprecision 1ps;

  `include "tb_vectors.svh"

  localparam vaddr_t      BOOT_ADDR      = 32'h0000_1000;
  localparam int          RESET_CYCLES   = 16;
  localparam logic [31:0] SEED           = 32'h5b28_fe61;
  // row stall plus up to 3 random extra cycles
  localparam int          MAX_STALL      = ROW_STALL_MAX + 3;
  localparam int          TIMEOUT_CYCLES = NUM_ROWS * (MAX_STALL + 6) + RESET_CYCLES;

  logic   clk_i;
  logic   rst_ni;
  vaddr_t boot_addr_i;
  logic   fetch_valid_i;
  instr_u fetch_instr_i;
  logic   fetch_ready_o;
  vaddr_t fetch_addr_o;
  logic   redirect_valid_i;
  vaddr_t redirect_pc_i;
  logic   resolve_valid_i;
  vaddr_t resolve_pc_i;
  logic   resolve_taken_i;
  logic   entry_valid_o;
  vaddr_t entry_pc_o;
  instr_u entry_instr_o;
  logic   entry_pred_taken_o;
  vaddr_t entry_pred_target_o;
  logic   entry_ready_i;

  // reference model state
  vaddr_t   model_addr;
  logic     model_valid [`FE_BHT_ENTRIES];
  bht_cnt_t model_cnt [`FE_BHT_ENTRIES];
  int       cycle_count;

  fetch_frontend u_fetch_frontend (
    .clk_i               (clk_i),
    .rst_ni              (rst_ni),
    .boot_addr_i         (boot_addr_i),
    .fetch_valid_i       (fetch_valid_i),
    .fetch_instr_i       (fetch_instr_i),
    .fetch_ready_o       (fetch_ready_o),
    .fetch_addr_o        (fetch_addr_o),
    .redirect_valid_i    (redirect_valid_i),
    .redirect_pc_i       (redirect_pc_i),
    .resolve_valid_i     (resolve_valid_i),
    .resolve_pc_i        (resolve_pc_i),
    .resolve_taken_i     (resolve_taken_i),
    .entry_valid_o       (entry_valid_o),
    .entry_pc_o          (entry_pc_o),
    .entry_instr_o       (entry_instr_o),
    .entry_pred_taken_o  (entry_pred_taken_o),
    .entry_pred_target_o (entry_pred_target_o),
    .entry_ready_i       (entry_ready_i)
  );

  // 4 ns period
  always #2 clk_i = ~clk_i;

  always @(posedge clk_i) begin
    cycle_count <= cycle_count + 1;
    if (cycle_count >= TIMEOUT_CYCLES) begin
      $display("timeout: the rows did not finish within %0d cycles", TIMEOUT_CYCLES);
      $display("Testbench failed");
      $fatal(1);
    end
  end

  // ------------------------------
  // reference model
  // ------------------------------
  function automatic logic [31:0] next_random(input logic [31:0] s);
    logic [31:0] x;
    x = s;
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  // pc-relative offset from the raw bit positions of the word
  function automatic vaddr_t expected_offset(input logic [31:0] w);
    case (w[6:0])
      `FE_OPC_BRANCH: return {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
      `FE_OPC_JAL:    return {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      default:        return '0;
    endcase
  endfunction

  function automatic logic expected_taken(input logic [31:0] w, input vaddr_t pc);
    int idx;
    idx = int'(pc[`FE_BHT_IDX_W+1:2]);
    case (w[6:0])
      `FE_OPC_JAL:    return 1'b1;
      // untrained entry falls back to the offset sign bit
      `FE_OPC_BRANCH: return model_valid[idx] ? model_cnt[idx][1] : w[31];
      default:        return 1'b0;
    endcase
  endfunction

  task automatic train_model(input vaddr_t pc, input logic taken);
    int idx;
    idx = int'(pc[`FE_BHT_IDX_W+1:2]);
    if (!model_valid[idx]) begin
      model_valid[idx] = 1'b1;
      model_cnt[idx]   = taken ? bht_cnt_t'(2) : bht_cnt_t'(1);
    end else if (taken && model_cnt[idx] != bht_cnt_t'(3)) begin
      model_cnt[idx] = model_cnt[idx] + bht_cnt_t'(1);
    end else if (!taken && model_cnt[idx] != bht_cnt_t'(0)) begin
      model_cnt[idx] = model_cnt[idx] - bht_cnt_t'(1);
    end
  endtask

  // ------------------------------
  // compare tasks
  // ------------------------------
  task automatic check_addr(input string name, input vaddr_t got, input vaddr_t exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_instr(input string name, input instr_u got, input instr_u exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  task automatic check_bit(input string name, input logic got, input logic exp);
    if (got !== exp) begin
      $display("mismatch %s: got %h expected %h", name, got, exp);
      $display("Testbench failed");
      $fatal(1);
    end
  endtask

  // held entry plus stalled fetch side
  task automatic check_held(input vaddr_t pc, input instr_u instr, input logic taken,
                            input vaddr_t target);
    check_bit("entry_valid_o", entry_valid_o, 1'b1);
    check_addr("entry_pc_o", entry_pc_o, pc);
    check_instr("entry_instr_o", entry_instr_o, instr);
    check_bit("entry_pred_taken_o", entry_pred_taken_o, taken);
    check_addr("entry_pred_target_o", entry_pred_target_o, target);
    check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
    check_addr("fetch_addr_o", fetch_addr_o, model_addr);
  endtask

  // ------------------------------
  // stimulus
  // ------------------------------
  initial begin : main
    vec_row_t    row;
    vaddr_t      exp_pc;
    vaddr_t      exp_target;
    logic        exp_taken;
    int          stalls;
    logic [31:0] rng;
    rng              = SEED;
    cycle_count      = 0;
    clk_i            = 1'b0;
    rst_ni           = 1'b0;
    boot_addr_i      = BOOT_ADDR;
    fetch_valid_i    = 1'b0;
    fetch_instr_i    = '0;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;
    resolve_valid_i  = 1'b0;
    resolve_pc_i     = '0;
    resolve_taken_i  = 1'b0;
    entry_ready_i    = 1'b0;
    for (int i = 0; i < `FE_BHT_ENTRIES; i++) begin
      model_valid[i] = 1'b0;
      model_cnt[i]   = '0;
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    #0.5 rst_ni = 1'b1;
    @(negedge clk_i);
    check_addr("fetch_addr_o", fetch_addr_o, BOOT_ADDR);
    check_bit("entry_valid_o", entry_valid_o, 1'b0);
    check_bit("fetch_ready_o", fetch_ready_o, 1'b1);
    model_addr = BOOT_ADDR;

    for (int r = 0; r < NUM_ROWS; r++) begin
      row = vector_row(r);
      // offer the word while the previous entry drains
      @(posedge clk_i);
      #0.5;
      fetch_valid_i   = 1'b1;
      fetch_instr_i   = row.instr;
      entry_ready_i   = 1'b1;
      resolve_valid_i = row.res_valid;
      resolve_pc_i    = row.res_pc;
      resolve_taken_i = row.res_taken;
      @(negedge clk_i);
      while (!fetch_ready_o) @(negedge clk_i);
      check_addr("fetch_addr_o", fetch_addr_o, model_addr);
      // prediction sees the counter before this edge's resolve
      exp_pc     = model_addr;
      exp_taken  = expected_taken(row.instr, exp_pc);
      exp_target = exp_pc + expected_offset(row.instr);
      model_addr = exp_taken ? exp_target : exp_pc + 32'd4;
      if (row.res_valid) begin
        train_model(row.res_pc, row.res_taken);
      end
      @(posedge clk_i);
      #0.5;
      fetch_valid_i   = 1'b0;
      resolve_valid_i = 1'b0;
      entry_ready_i   = 1'b0;
      // entry must show up one cycle after the accept
      @(negedge clk_i);
      check_held(exp_pc, row.instr, exp_taken, exp_target);
      rng    = next_random(rng);
      stalls = int'(row.stall) + int'(rng & 32'd3);
      repeat (stalls) begin
        @(negedge clk_i);
        check_held(exp_pc, row.instr, exp_taken, exp_target);
      end
      if (row.redir_valid) begin
        @(posedge clk_i);
        #0.5;
        redirect_valid_i = 1'b1;
        redirect_pc_i    = row.redir_pc;
        // a word is offered during the redirect and decode is ready on some rows
        // so only the redirect can hold fetch_ready_o low there
        fetch_valid_i    = 1'b1;
        entry_ready_i    = r[1];
        @(negedge clk_i);
        check_bit("fetch_ready_o", fetch_ready_o, 1'b0);
        @(posedge clk_i);
        #0.5;
        redirect_valid_i = 1'b0;
        fetch_valid_i    = 1'b0;
        entry_ready_i    = 1'b0;
        @(negedge clk_i);
        check_bit("entry_valid_o", entry_valid_o, 1'b0);
        check_addr("fetch_addr_o", fetch_addr_o, row.redir_pc);
        model_addr = row.redir_pc;
      end
    end

    // drain the last entry
    @(posedge clk_i);
    #0.5 entry_ready_i = 1'b1;
    @(negedge clk_i);
    @(negedge clk_i);
    check_bit("entry_valid_o", entry_valid_o, 1'b0);
    $display("Testbench passed");
    $finish;
  end

endmodule

`default_nettype wire

// File: sources.f
+incdir+design
+incdir+testbench
design/frontend_pkg.sv
design/instr_scan.sv
design/branch_history.sv
design/fetch_pc_gen.sv
design/fetch_frontend.sv
testbench/tb_fetch_frontend.sv
